// File: Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= cpu.f
BUILD_DIR ?= build

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR"

test:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf $(BUILD_DIR)

// File: cpu.f
design/cpu_pkg.sv
design/inst_buffer.sv
design/dispatch.sv
design/map_table.sv
design/free_list.sv
design/rs.sv
design/regfile.sv
design/alu.sv
design/rob.sv
design/cpu.sv
testbench/cpu_tb.sv

// File: testbench/cpu_tb.sv
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLOCK_PERIOD = 20;
    localparam int NUM_RANDOM   = 300;
    localparam int IB_DEPTH     = 4;
    localparam int RS_SIZE      = 4;
    localparam int ROB_SIZE     = 8;

    typedef struct packed {
        inst_word_u inst;
        commit_t    want;
    } table_row_t;

    logic       clock;
    logic       reset;
    logic       in_valid;
    inst_word_u in_inst;
    logic       in_ready;
    logic       commit_valid;
    commit_t    commit;

    table_row_t rows [$];
    commit_t    pending [$];          // model commits not yet seen
    data_t      model_regs [NUM_ARCH_REGS];
    integer     seed = 32'hc4affbe1;
    int         accepted;
    int         committed = 0;
    int         total_insts;
    logic       saw_stall = 1'b0;

    cpu #(
        .IB_DEPTH(IB_DEPTH),
        .RS_SIZE (RS_SIZE),
        .ROB_SIZE(ROB_SIZE)
    ) uut (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .in_ready    (in_ready),
        .commit_valid(commit_valid),
        .commit      (commit)
    );

    initial clock = 1'b0;
    always #(CLOCK_PERIOD / 2) clock = ~clock;

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_on_error(input string reason);
        $display("ERROR: %s", reason);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_commit(input string what, input commit_t actual, input commit_t want);
        if (actual !== want) begin
            $display("CHECK FAILED %s: got arch_dest=%h value=%h, expected arch_dest=%h value=%h",
                     what, actual.arch_dest, actual.value, want.arch_dest, want.value);
            $display("Regression failed");
            $fatal(1, "commit mismatch");
        end
    endtask

    task automatic check_bit(input string what, input logic actual, input logic want);
        if (actual !== want) begin
            $display("CHECK FAILED %s: got %h, expected %h", what, actual, want);
            $display("Regression failed");
            $fatal(1, "control level mismatch");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // instruction encoding and reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic inst_word_u reg_word(input opcode_t op, input arch_reg_t d,
                                            input arch_reg_t s1, input arch_reg_t s2);
        inst_word_u w;
        w.r_form.opcode = op;
        w.r_form.dest   = d;
        w.r_form.src1   = s1;
        w.r_form.src2   = s2;
        w.r_form.spare  = 3'b000;
        return w;
    endfunction

    function automatic inst_word_u imm_word(input arch_reg_t d, input arch_reg_t s1,
                                            input logic [5:0] imm);
        inst_word_u w;
        w.i_form.opcode = OP_ADDI;
        w.i_form.dest   = d;
        w.i_form.src1   = s1;
        w.i_form.imm6   = imm;
        return w;
    endfunction

    // architectural result of one instruction, in program order
    function automatic commit_t model_step(input inst_word_u w);
        commit_t c;
        data_t   a;
        data_t   b;
        a = model_regs[w.r_form.src1];
        b = model_regs[w.r_form.src2];
        case (w.r_form.opcode)
            OP_ADD:  c.value = a + b;
            OP_SUB:  c.value = a - b;
            OP_AND:  c.value = a & b;
            OP_OR:   c.value = a | b;
            OP_XOR:  c.value = a ^ b;
            OP_ADDI: c.value = a + {{(DATA_WIDTH-6){w.i_form.imm6[5]}}, w.i_form.imm6};
            default: c.value = '0;
        endcase
        c.arch_dest = w.r_form.dest;
        model_regs[c.arch_dest] = c.value;
        return c;
    endfunction

    function automatic inst_word_u random_word();
        logic [31:0] r;
        int          sel;
        inst_word_u  w;
        r   = $random(seed);
        sel = int'(r[31:16] % 16'd6);
        case (sel)
            0:       w = reg_word(OP_ADD, r[2:0], r[5:3], r[8:6]);
            1:       w = reg_word(OP_SUB, r[2:0], r[5:3], r[8:6]);
            2:       w = reg_word(OP_AND, r[2:0], r[5:3], r[8:6]);
            3:       w = reg_word(OP_OR,  r[2:0], r[5:3], r[8:6]);
            4:       w = reg_word(OP_XOR, r[2:0], r[5:3], r[8:6]);
            default: w = imm_word(r[2:0], r[5:3], r[14:9]);
        endcase
        return w;
    endfunction

    task automatic add_row(input inst_word_u w, input arch_reg_t d, input data_t v);
        table_row_t row;
        row.inst           = w;
        row.want.arch_dest = d;
        row.want.value     = v;
        rows.push_back(row);
    endtask

    task automatic load_table();
        add_row(imm_word(3'd1, 3'd0, 6'h05), 3'd1, 16'h0005);          // first addi from r0
        add_row(imm_word(3'd2, 3'd1, 6'h03), 3'd2, 16'h0008);          // chain starts
        add_row(reg_word(OP_ADD, 3'd3, 3'd2, 3'd1), 3'd3, 16'h000d);
        add_row(reg_word(OP_SUB, 3'd4, 3'd3, 3'd2), 3'd4, 16'h0005);
        add_row(imm_word(3'd4, 3'd4, 6'h39), 3'd4, 16'hfffe);          // -7
        add_row(reg_word(OP_XOR, 3'd5, 3'd4, 3'd3), 3'd5, 16'hfff3);
        add_row(reg_word(OP_AND, 3'd6, 3'd5, 3'd3), 3'd6, 16'h0001);
        add_row(reg_word(OP_OR,  3'd7, 3'd6, 3'd4), 3'd7, 16'hffff);
        add_row(reg_word(OP_SUB, 3'd0, 3'd1, 3'd2), 3'd0, 16'hfffd);   // wraps below zero
        add_row(imm_word(3'd6, 3'd0, 6'h20), 3'd6, 16'hffdd);          // -32
        add_row(imm_word(3'd6, 3'd6, 6'h1f), 3'd6, 16'hfffc);          // +31
        // r1 chain with independent work in between
        add_row(imm_word(3'd1, 3'd1, 6'h01), 3'd1, 16'h0006);
        add_row(reg_word(OP_XOR, 3'd2, 3'd3, 3'd3), 3'd2, 16'h0000);
        add_row(imm_word(3'd1, 3'd1, 6'h01), 3'd1, 16'h0007);
        add_row(reg_word(OP_OR,  3'd3, 3'd7, 3'd3), 3'd3, 16'hffff);
        add_row(imm_word(3'd1, 3'd1, 6'h01), 3'd1, 16'h0008);
        add_row(reg_word(OP_AND, 3'd5, 3'd5, 3'd5), 3'd5, 16'hfff3);
        add_row(reg_word(OP_ADD, 3'd1, 3'd1, 3'd1), 3'd1, 16'h0010);
    endtask

    // present one word and hold it until the buffer takes it
    task automatic drive_inst(input inst_word_u w, output commit_t predicted);
        logic taken;
        taken = 1'b0;
        in_valid <= 1'b1;
        in_inst  <= w;
        while (!taken) begin
            @(negedge clock);
            taken = in_ready;    // in_ready only moves on the rising edge
            @(posedge clock);
        end
        predicted = model_step(w);
        pending.push_back(predicted);
        accepted++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // monitors and watchdog
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset && in_valid && !in_ready) saw_stall <= 1'b1;
        if (!reset && commit_valid) begin
            if (pending.size() == 0) begin
                stop_on_error("a commit arrived with no instruction outstanding");
            end else begin
                check_commit($sformatf("commit %0d", committed), commit, pending.pop_front());
                committed++;
            end
        end
    end

    initial begin
        longint limit_ns;
        wait (total_insts != 0);
        limit_ns = longint'(total_insts * 20 + 200) * CLOCK_PERIOD;
        #(limit_ns);
        stop_on_error("watchdog expired, commits stopped arriving");
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        commit_t predicted;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_inst  = '0;
        accepted = 0;
        for (int i = 0; i < NUM_ARCH_REGS; i++) model_regs[i] = '0;
        load_table();
        total_insts = rows.size() + NUM_RANDOM;

        repeat (2) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        check_bit("in_ready", in_ready, 1'b1);
        check_bit("commit_valid", commit_valid, 1'b0);

        // in_valid stays high from here to the last random word
        @(posedge clock);
        foreach (rows[i]) begin
            drive_inst(rows[i].inst, predicted);
            check_commit($sformatf("model for row %0d", i), predicted, rows[i].want);
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            drive_inst(random_word(), predicted);
        end
        in_valid <= 1'b0;

        while (committed != accepted) @(posedge clock);
        repeat (4) @(posedge clock);      // room for a stray extra commit
        @(negedge clock);
        check_bit("in_ready", in_ready, 1'b1);
        check_bit("commit_valid", commit_valid, 1'b0);
        check_bit("in_ready low during burst", saw_stall, 1'b1);

        if (pending.size() == 0 && committed == total_insts) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("ERROR: %0d commits for %0d instructions", committed, total_insts);
            $display("Regression failed");
            $fatal(1, "commit count mismatch");
        end
    end

endmodule

`default_nettype wire

// File: design/cpu.sv
`default_nettype none

module cpu import cpu_pkg::*; #(
    parameter int IB_DEPTH = 4,
    parameter int RS_SIZE  = 4,
    parameter int ROB_SIZE = 8
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       in_valid,
    input  inst_word_u in_inst,
    output logic       in_ready,
    output logic       commit_valid,
    output commit_t    commit
);
    ////////////////////////////////////////////////////////////////////////////
    // pipeline wires
    ////////////////////////////////////////////////////////////////////////////

    logic       head_valid;
    inst_word_u head_inst;
    logic       dispatch_en;
    arch_reg_t  src1_arch, src2_arch, dest_arch;
    renamed_t   renamed;

    phys_reg_t  src1_map, src2_map, t_old;
    logic       src1_ready, src2_ready;

    phys_reg_t  fl_reg;        // next free register
    logic       fl_empty;
    logic       free_en;       // retire returns t_old
    phys_reg_t  free_reg;

    logic       rs_full, rob_full;
    phys_reg_t  rd_idx_1, rd_idx_2;
    data_t      rd_data_1, rd_data_2;
    issue_t     issued;
    cdb_t       cdb;           // single producer, the alu

    ////////////////////////////////////////////////////////////////////////////
    // front end and rename
    ////////////////////////////////////////////////////////////////////////////

    inst_buffer #(.IB_DEPTH(IB_DEPTH)) u_inst_buffer (
        .clock(clock), .reset(reset),
        .in_valid(in_valid), .in_inst(in_inst), .in_ready(in_ready),
        .head_valid(head_valid), .head_inst(head_inst), .pop(dispatch_en)
    );

    dispatch u_dispatch (
        .head_valid(head_valid), .head_inst(head_inst),
        .fl_empty(fl_empty), .fl_reg(fl_reg),
        .rs_full(rs_full), .rob_full(rob_full),
        .src1_map(src1_map), .src1_ready(src1_ready),
        .src2_map(src2_map), .src2_ready(src2_ready),
        .t_old(t_old), .cdb(cdb),
        .dispatch_en(dispatch_en),
        .src1_arch(src1_arch), .src2_arch(src2_arch), .dest_arch(dest_arch),
        .renamed(renamed)
    );

    map_table u_map_table (
        .clock(clock), .reset(reset),
        .src1_arch(src1_arch), .src2_arch(src2_arch), .dest_arch(dest_arch),
        .rename_en(dispatch_en), .new_reg(fl_reg), .cdb(cdb),
        .src1_map(src1_map), .src1_ready(src1_ready),
        .src2_map(src2_map), .src2_ready(src2_ready),
        .t_old(t_old)
    );

    free_list u_free_list (
        .clock(clock), .reset(reset),
        .pop(dispatch_en), .free_reg(fl_reg), .empty(fl_empty),
        .push(free_en), .push_reg(free_reg)
    );

    ////////////////////////////////////////////////////////////////////////////
    // issue, execute, retire
    ////////////////////////////////////////////////////////////////////////////

    rs #(.RS_SIZE(RS_SIZE)) u_rs (
        .clock(clock), .reset(reset),
        .alloc(dispatch_en), .renamed(renamed), .cdb(cdb), .full(rs_full),
        .rd_idx_1(rd_idx_1), .rd_idx_2(rd_idx_2),
        .rd_data_1(rd_data_1), .rd_data_2(rd_data_2),
        .issued(issued)
    );

    regfile u_regfile (
        .clock(clock), .reset(reset),
        .rd_idx_1(rd_idx_1), .rd_idx_2(rd_idx_2),
        .rd_data_1(rd_data_1), .rd_data_2(rd_data_2),
        .cdb(cdb)
    );

    alu u_alu (
        .clock(clock), .reset(reset),
        .issued(issued), .cdb(cdb)
    );

    rob #(.ROB_SIZE(ROB_SIZE)) u_rob (
        .clock(clock), .reset(reset),
        .alloc(dispatch_en), .renamed(renamed), .cdb(cdb), .full(rob_full),
        .commit_valid(commit_valid), .commit(commit),
        .free_en(free_en), .free_reg(free_reg)
    );

endmodule

`default_nettype wire

// File: design/rob.sv
`default_nettype none

module rob import cpu_pkg::*; #(
    parameter int ROB_SIZE = 8
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      alloc,
    input  renamed_t  renamed,
    input  cdb_t      cdb,
    output logic      full,
    output logic      commit_valid,
    output commit_t   commit,
    output logic      free_en,
    output phys_reg_t free_reg
);
    localparam int PW = (ROB_SIZE > 1) ? $clog2(ROB_SIZE) : 1;

    typedef struct packed {
        arch_reg_t arch_dest;
        phys_reg_t dest;
        phys_reg_t t_old;
        data_t     value;
    } rob_entry_t;

    rob_entry_t                    entries [ROB_SIZE];
    logic [ROB_SIZE-1:0]           valid, done;
    logic [PW-1:0]                 head, tail;
    logic [$clog2(ROB_SIZE+1)-1:0] count;
    logic                          retire;

    assign full     = (count == ROB_SIZE);
    assign retire   = valid[head] && done[head];
    assign free_en  = retire;               // old mapping goes back this edge
    assign free_reg = entries[head].t_old;

    ////////////////////////////////////////////////////////////////////////////
    // allocate at tail, complete from the bus, retire at head
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (alloc) begin
            entries[tail].arch_dest <= renamed.arch_dest;
            entries[tail].dest      <= renamed.dest;
            entries[tail].t_old     <= renamed.t_old;
        end
        for (int i = 0; i < ROB_SIZE; i++) begin
            if (cdb.valid && valid[i] && entries[i].dest == cdb.dest) entries[i].value <= cdb.value;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            done  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            for (int i = 0; i < ROB_SIZE; i++) begin
                if (cdb.valid && valid[i] && entries[i].dest == cdb.dest) done[i] <= 1'b1;
            end
            if (retire) begin
                valid[head] <= 1'b0;
                head        <= (head == PW'(ROB_SIZE - 1)) ? '0 : head + 1'b1;
            end
            if (alloc) begin
                valid[tail] <= 1'b1;
                done[tail]  <= 1'b0;
                tail        <= (tail == PW'(ROB_SIZE - 1)) ? '0 : tail + 1'b1;
            end
            if (alloc && !retire)      count <= count + 1'b1;
            else if (retire && !alloc) count <= count - 1'b1;
        end
    end

    // commit pulse, one cycle per retired entry
    always_ff @(posedge clock) begin
        commit.arch_dest <= entries[head].arch_dest;
        commit.value     <= entries[head].value;
        if (reset) commit_valid <= 1'b0;
        else       commit_valid <= retire;
    end

endmodule

`default_nettype wire

// File: design/alu.sv
`default_nettype none

module alu import cpu_pkg::*; (
    input  logic   clock,
    input  logic   reset,
    input  issue_t issued,
    output cdb_t   cdb
);
    data_t result;

    always_comb begin
        case (issued.opcode)
            OP_SUB:  result = issued.a - issued.b;   // wraps mod 2^16
            OP_AND:  result = issued.a & issued.b;
            OP_OR:   result = issued.a | issued.b;
            OP_XOR:  result = issued.a ^ issued.b;
            default: result = issued.a + issued.b;   // add, addi
        endcase
    end

    always_ff @(posedge clock) begin
        cdb.dest  <= issued.dest;
        cdb.value <= result;
        if (reset) cdb.valid <= 1'b0;
        else       cdb.valid <= issued.valid;
    end

endmodule

`default_nettype wire

// File: design/regfile.sv
`default_nettype none

module regfile import cpu_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  phys_reg_t rd_idx_1,
    input  phys_reg_t rd_idx_2,
    output data_t     rd_data_1,
    output data_t     rd_data_2,
    input  cdb_t      cdb
);
    data_t regs [NUM_PHYS_REGS];

    // bypass the write landing this cycle
    assign rd_data_1 = (cdb.valid && cdb.dest == rd_idx_1) ? cdb.value : regs[rd_idx_1];
    assign rd_data_2 = (cdb.valid && cdb.dest == rd_idx_2) ? cdb.value : regs[rd_idx_2];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_PHYS_REGS; i++) regs[i] <= '0;
        end else if (cdb.valid) begin
            regs[cdb.dest] <= cdb.value;
        end
    end

endmodule

`default_nettype wire

// File: design/rs.sv
`default_nettype none

module rs import cpu_pkg::*; #(
    parameter int RS_SIZE = 4
) (
    input  logic      clock,
    input  logic      reset,
    input  logic      alloc,
    input  renamed_t  renamed,
    input  cdb_t      cdb,
    output logic      full,
    output phys_reg_t rd_idx_1,
    output phys_reg_t rd_idx_2,
    input  data_t     rd_data_1,
    input  data_t     rd_data_2,
    output issue_t    issued
);
    localparam int IW = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1;

    renamed_t      slots [RS_SIZE];
    logic          sel_found, free_found;
    logic [IW-1:0] sel_idx, free_idx;
    issue_t        issue_next;

    ////////////////////////////////////////////////////////////////////////////
    // oldest-ready select and free slot search, both lowest index first
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        sel_found  = 1'b0;
        sel_idx    = '0;
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (slots[i].valid && slots[i].src1_ready && slots[i].src2_ready) begin
                sel_found = 1'b1;
                sel_idx   = IW'(i);
            end
            if (!slots[i].valid) begin
                free_found = 1'b1;
                free_idx   = IW'(i);
            end
        end
    end

    assign full     = !free_found;
    assign rd_idx_1 = slots[sel_idx].src1;
    assign rd_idx_2 = slots[sel_idx].src2;

    always_comb begin
        issue_next.valid  = sel_found;
        issue_next.opcode = slots[sel_idx].opcode;
        issue_next.dest   = slots[sel_idx].dest;
        issue_next.a      = rd_data_1;
        issue_next.b      = slots[sel_idx].use_imm ? slots[sel_idx].imm : rd_data_2;
    end

    always_ff @(posedge clock) begin
        issued <= issue_next;
        if (reset) issued.valid <= 1'b0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // slot update: wakeup, release on issue, allocate
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < RS_SIZE; i++) slots[i].valid <= 1'b0;
        end else begin
            for (int i = 0; i < RS_SIZE; i++) begin
                if (cdb.valid && slots[i].src1 == cdb.dest) slots[i].src1_ready <= 1'b1;
                if (cdb.valid && slots[i].src2 == cdb.dest) slots[i].src2_ready <= 1'b1;
            end
            if (sel_found) slots[sel_idx].valid <= 1'b0;
            if (alloc) slots[free_idx] <= renamed;   // never the slot just issued
        end
    end

endmodule

`default_nettype wire

// File: design/free_list.sv
`default_nettype none

module free_list import cpu_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      pop,
    output phys_reg_t free_reg,
    output logic      empty,
    input  logic      push,
    input  phys_reg_t push_reg
);
    localparam int FL_SIZE = NUM_PHYS_REGS - NUM_ARCH_REGS;
    localparam int PW      = (FL_SIZE > 1) ? $clog2(FL_SIZE) : 1;

    phys_reg_t                    q [FL_SIZE];
    logic [PW-1:0]                head, tail;
    logic [$clog2(FL_SIZE+1)-1:0] count;

    assign free_reg = q[head];
    assign empty    = (count == 0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < FL_SIZE; i++) q[i] <= phys_reg_t'(NUM_ARCH_REGS + i);
            head  <= '0;
            tail  <= '0;
            count <= FL_SIZE[$clog2(FL_SIZE+1)-1:0];   // upper registers all free
        end else begin
            if (push) begin
                q[tail] <= push_reg;
                tail    <= (tail == PW'(FL_SIZE - 1)) ? '0 : tail + 1'b1;
            end
            if (pop) head <= (head == PW'(FL_SIZE - 1)) ? '0 : head + 1'b1;
            if (push && !pop)      count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/map_table.sv
`default_nettype none

module map_table import cpu_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  arch_reg_t src1_arch,
    input  arch_reg_t src2_arch,
    input  arch_reg_t dest_arch,
    input  logic      rename_en,
    input  phys_reg_t new_reg,
    input  cdb_t      cdb,
    output phys_reg_t src1_map,
    output logic      src1_ready,
    output phys_reg_t src2_map,
    output logic      src2_ready,
    output phys_reg_t t_old
);
    phys_reg_t map   [NUM_ARCH_REGS];
    logic      ready [NUM_ARCH_REGS];

    assign src1_map   = map[src1_arch];
    assign src1_ready = ready[src1_arch];
    assign src2_map   = map[src2_arch];
    assign src2_ready = ready[src2_arch];
    assign t_old      = map[dest_arch];   // old mapping, read before the rename lands

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map[i]   <= phys_reg_t'(i);
                ready[i] <= 1'b1;
            end
        end else begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                if (cdb.valid && map[i] == cdb.dest) ready[i] <= 1'b1;
            end
            // a rename in the same cycle wins over the wakeup
            if (rename_en) begin
                map[dest_arch]   <= new_reg;
                ready[dest_arch] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/dispatch.sv
`default_nettype none

module dispatch import cpu_pkg::*; (
    input  logic       head_valid,
    input  inst_word_u head_inst,
    input  logic       fl_empty,
    input  phys_reg_t  fl_reg,
    input  logic       rs_full,
    input  logic       rob_full,
    input  phys_reg_t  src1_map,
    input  logic       src1_ready,
    input  phys_reg_t  src2_map,
    input  logic       src2_ready,
    input  phys_reg_t  t_old,
    input  cdb_t       cdb,
    output logic       dispatch_en,
    output arch_reg_t  src1_arch,
    output arch_reg_t  src2_arch,
    output arch_reg_t  dest_arch,
    output renamed_t   renamed
);
    logic  use_imm;
    data_t imm;

    // all four resources must be available this cycle
    assign dispatch_en = head_valid && !fl_empty && !rs_full && !rob_full;

    always_comb begin
        use_imm   = 1'b0;
        imm       = '0;
        dest_arch = head_inst.r_form.dest;
        src1_arch = head_inst.r_form.src1;
        src2_arch = head_inst.r_form.src2;
        if (head_inst.r_form.opcode == OP_ADDI) begin
            use_imm   = 1'b1;
            imm       = {{(DATA_WIDTH-6){head_inst.i_form.imm6[5]}}, head_inst.i_form.imm6};
        end
    end

    always_comb begin
        renamed            = '0;
        renamed.valid      = dispatch_en;
        renamed.opcode     = head_inst.r_form.opcode;
        renamed.dest       = fl_reg;
        renamed.t_old      = t_old;
        renamed.arch_dest  = dest_arch;
        renamed.src1       = src1_map;
        renamed.src2       = src2_map;
        // snoop the bus so a value landing this cycle is not missed
        renamed.src1_ready = src1_ready || (cdb.valid && cdb.dest == src1_map);
        renamed.src2_ready = use_imm || src2_ready || (cdb.valid && cdb.dest == src2_map);
        renamed.use_imm    = use_imm;
        renamed.imm        = imm;
    end

endmodule

`default_nettype wire

// File: design/inst_buffer.sv
`default_nettype none

module inst_buffer import cpu_pkg::*; #(
    parameter int IB_DEPTH = 4
) (
    input  logic       clock,
    input  logic       reset,
    input  logic       in_valid,
    input  inst_word_u in_inst,
    output logic       in_ready,
    output logic       head_valid,
    output inst_word_u head_inst,
    input  logic       pop
);
    localparam int PW = (IB_DEPTH > 1) ? $clog2(IB_DEPTH) : 1;

    inst_word_u              mem [IB_DEPTH];
    logic [PW-1:0]           head, tail;
    logic [$clog2(IB_DEPTH+1)-1:0] count;
    logic                    push;

    assign in_ready   = (count != IB_DEPTH);
    assign push       = in_valid && in_ready;
    assign head_valid = (count != 0);
    assign head_inst  = mem[head];

    always_ff @(posedge clock) begin
        if (push) mem[tail] <= in_inst;   // raw word, decoded later
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) tail <= (tail == PW'(IB_DEPTH - 1)) ? '0 : tail + 1'b1;
            if (pop)  head <= (head == PW'(IB_DEPTH - 1)) ? '0 : head + 1'b1;
            if (push && !pop)      count <= count + 1'b1;
            else if (pop && !push) count <= count - 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths fixed by the instruction encoding
    ////////////////////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH    = 16;
    localparam int NUM_ARCH_REGS = 8;
    localparam int NUM_PHYS_REGS = 16;

    typedef logic [$clog2(NUM_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(NUM_PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [DATA_WIDTH-1:0]            data_t;

    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_XOR  = 4'h4,
        OP_ADDI = 4'h5
    } opcode_t;

    ////////////////////////////////////////////////////////////////////////////
    // instruction word, two views of the same 16 bits
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        opcode_t   opcode;
        arch_reg_t dest;
        arch_reg_t src1;
        arch_reg_t src2;
        logic [2:0] spare;
    } r_form_t;

    typedef struct packed {
        opcode_t    opcode;
        arch_reg_t  dest;
        arch_reg_t  src1;
        logic [5:0] imm6;   // signed
    } i_form_t;

    typedef union packed {
        r_form_t r_form;
        i_form_t i_form;
    } inst_word_u;

    ////////////////////////////////////////////////////////////////////////////
    // pipeline packets
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic      valid;
        opcode_t   opcode;
        phys_reg_t dest;
        phys_reg_t t_old;      // mapping replaced by dest
        arch_reg_t arch_dest;
        phys_reg_t src1;
        logic      src1_ready;
        phys_reg_t src2;
        logic      src2_ready;
        logic      use_imm;
        data_t     imm;        // already sign extended
    } renamed_t;

    typedef struct packed {
        logic      valid;
        opcode_t   opcode;
        phys_reg_t dest;
        data_t     a;
        data_t     b;
    } issue_t;

    typedef struct packed {
        logic      valid;
        phys_reg_t dest;
        data_t     value;
    } cdb_t;

    typedef struct packed {
        arch_reg_t arch_dest;
        data_t     value;
    } commit_t;

endpackage

`default_nettype wire
